//--- Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing -Wno-fatal
TOP        = tb_rab_cfg
FILELIST   = all.f
OBJ_DIR    = obj_dir
PASS_MSG   = Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+verif
common/rab_cfg_pkg.sv
axi_lite_slave/axi_lite_slave.sv
design/cfg_reg_bank.sv
design/l2_tlb_write_port.sv
design/rab_cfg_top.sv
verif/tb_rab_cfg.sv

//--- axi_lite_slave/axi_lite_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_slave
(
   input  wire logic                                   s_axi_aclk,
   input  wire logic                                   s_axi_aresetn,
   input  wire logic [rab_cfg_pkg::data_width-1:0]     s_axi_awaddr,
   input  wire logic                                   s_axi_awvalid,
   output logic                                        s_axi_awready,
   input  wire logic [rab_cfg_pkg::data_width-1:0]     s_axi_wdata,
   input  wire logic [rab_cfg_pkg::strb_width-1:0]     s_axi_wstrb,
   input  wire logic                                   s_axi_wvalid,
   output logic                                        s_axi_wready,
   output rab_cfg_pkg::axi_resp_t                      s_axi_bresp,
   output logic                                        s_axi_bvalid,
   input  wire logic                                   s_axi_bready,
   input  wire logic [rab_cfg_pkg::data_width-1:0]     s_axi_araddr,
   input  wire logic                                   s_axi_arvalid,
   output logic                                        s_axi_arready,
   output logic [rab_cfg_pkg::data_width-1:0]          s_axi_rdata,
   output rab_cfg_pkg::axi_resp_t                      s_axi_rresp,
   output logic                                        s_axi_rvalid,
   input  wire logic                                   s_axi_rready,
   input  wire logic [rab_cfg_pkg::data_width-1:0]     rdata,
   output rab_cfg_pkg::cfg_write_t                     wr,
   output rab_cfg_pkg::cfg_read_t                      rd
);

   rab_cfg_pkg::wr_state_t state_q;
   rab_cfg_pkg::wr_state_t state_d;

   logic [rab_cfg_pkg::data_width-1:0] waddr_q;
   logic [rab_cfg_pkg::data_width-1:0] wdata_q;
   logic [rab_cfg_pkg::strb_width-1:0] wstrb_q;

   logic aw_hs;
   logic w_hs;
   logic ar_hs;

   // **************************************************
   // write channels
   // **************************************************

   assign s_axi_awready = (state_q == rab_cfg_pkg::wr_idle) ||
                          (state_q == rab_cfg_pkg::wr_have_data);
   assign s_axi_wready  = (state_q == rab_cfg_pkg::wr_idle) ||
                          (state_q == rab_cfg_pkg::wr_have_addr);
   assign s_axi_bvalid  = (state_q == rab_cfg_pkg::wr_update) ||
                          (state_q == rab_cfg_pkg::wr_resp);
   assign s_axi_bresp   = rab_cfg_pkg::resp_okay;

   assign aw_hs = s_axi_awvalid && s_axi_awready;
   assign w_hs  = s_axi_wvalid && s_axi_wready;

   always_comb
   begin
      state_d = state_q;
      unique case (state_q)
         rab_cfg_pkg::wr_idle:
         begin
            if (aw_hs && w_hs)
               state_d = rab_cfg_pkg::wr_update;
            else if (aw_hs)
               state_d = rab_cfg_pkg::wr_have_addr;
            else if (w_hs)
               state_d = rab_cfg_pkg::wr_have_data;
         end
         rab_cfg_pkg::wr_have_addr:
            if (w_hs) state_d = rab_cfg_pkg::wr_update;
         rab_cfg_pkg::wr_have_data:
            if (aw_hs) state_d = rab_cfg_pkg::wr_update;
         rab_cfg_pkg::wr_update:   // bresp may complete in the pulse cycle
            state_d = s_axi_bready ? rab_cfg_pkg::wr_idle : rab_cfg_pkg::wr_resp;
         rab_cfg_pkg::wr_resp:
            if (s_axi_bready) state_d = rab_cfg_pkg::wr_idle;
         default:
            state_d = rab_cfg_pkg::wr_idle;
      endcase
   end

   always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
   begin
      if (!s_axi_aresetn)
      begin
         state_q <= rab_cfg_pkg::wr_idle;
         waddr_q <= '0;
         wdata_q <= '0;
         wstrb_q <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (aw_hs)
            waddr_q <= s_axi_awaddr;
         if (w_hs)
         begin
            wdata_q <= s_axi_wdata;
            wstrb_q <= s_axi_wstrb;
         end
      end
   end

   // single pulse to bank and tlb ports
   assign wr.valid = (state_q == rab_cfg_pkg::wr_update);
   assign wr.addr  = waddr_q;
   assign wr.data  = wdata_q;
   assign wr.strb  = wstrb_q;

   // **************************************************
   // read channels
   // **************************************************

   assign s_axi_arready = !s_axi_rvalid;   // one read in flight
   assign s_axi_rresp   = rab_cfg_pkg::resp_okay;
   assign ar_hs         = s_axi_arvalid && s_axi_arready;

   // bank decodes the live address so rdata can be captured on the ar edge
   assign rd.addr = s_axi_araddr;

   always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_rvalid <= 1'b0;
         s_axi_rdata  <= '0;
      end
      else if (ar_hs)
      begin
         s_axi_rvalid <= 1'b1;
         s_axi_rdata  <= rdata;
      end
      else if (s_axi_rready)
         s_axi_rvalid <= 1'b0;   // data held until then
   end

endmodule

`default_nettype wire

//--- common/rab_cfg_pkg.sv
`default_nettype none

package rab_cfg_pkg;

   // **************************************************
   // widths and address map
   // **************************************************

   // register words are exactly one bus word
   localparam int data_width = 32;
   localparam int strb_width = data_width / 8;

   // every window (config regs, each tlb port) spans this many bytes
   localparam logic [data_width-1:0] region_size = 32'h0000_8000;

   // word index into the bank, taken from addr[2] upward
   localparam int reg_idx_width = 8;

   // **************************************************
   // types
   // **************************************************

   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_slverr = 2'b10
   } axi_resp_t;

   typedef enum logic [2:0] {
      wr_idle,
      wr_have_addr,   // aw taken, waiting on w
      wr_have_data,   // w taken, waiting on aw
      wr_update,      // one-cycle write pulse
      wr_resp         // bvalid held until bready
   } wr_state_t;

   // one accepted write, broadcast to all consumers
   typedef struct packed {
      logic                  valid;
      logic [data_width-1:0] addr;
      logic [data_width-1:0] data;
      logic [strb_width-1:0] strb;
   } cfg_write_t;

   typedef struct packed {
      logic [data_width-1:0] addr;
   } cfg_read_t;

   // l2 tlb write, addr is a word address within the port window
   typedef struct packed {
      logic                  wren;
      logic [data_width-1:0] addr;
      logic [data_width-1:0] data;
   } tlb_write_t;

endpackage

`default_nettype wire

//--- design/cfg_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_reg_bank #(
   parameter int reg_entries = 196
)
(
   input  wire logic                                              s_axi_aclk,
   input  wire logic                                              s_axi_aresetn,
   input  wire rab_cfg_pkg::cfg_write_t                           wr,
   input  wire rab_cfg_pkg::cfg_read_t                            rd,
   output logic [rab_cfg_pkg::data_width-1:0]                     rdata,
   output logic [reg_entries-1:0][rab_cfg_pkg::data_width-1:0]    cfg_regs
);

   logic [rab_cfg_pkg::reg_idx_width-1:0] wr_idx;
   logic [rab_cfg_pkg::reg_idx_width-1:0] rd_idx;
   logic                                  wr_hit;
   logic                                  rd_hit;

   // **************************************************
   // address decode
   // **************************************************

   assign wr_idx = wr.addr[rab_cfg_pkg::reg_idx_width+1:2];
   assign rd_idx = rd.addr[rab_cfg_pkg::reg_idx_width+1:2];

   // full word offset is compared, so high bits cannot alias low entries
   assign wr_hit = (wr.addr < rab_cfg_pkg::region_size) &&
                   (wr.addr[rab_cfg_pkg::data_width-1:2] < reg_entries);
   assign rd_hit = (rd.addr < rab_cfg_pkg::region_size) &&
                   (rd.addr[rab_cfg_pkg::data_width-1:2] < reg_entries);

   // **************************************************
   // register array
   // **************************************************

   always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
   begin
      if (!s_axi_aresetn)
         cfg_regs <= '0;
      else if (wr.valid && wr_hit)
      begin
         for (int b = 0; b < rab_cfg_pkg::strb_width; b++)
         begin
            if (wr.strb[b])   // untouched lanes keep old bytes
               cfg_regs[wr_idx][b*8 +: 8] <= wr.data[b*8 +: 8];
         end
      end
   end

   // read mux, zero outside the bank
   always_comb
   begin
      rdata = '0;
      if (rd_hit)
         rdata = cfg_regs[rd_idx];
   end

endmodule

`default_nettype wire

//--- design/l2_tlb_write_port.sv
`timescale 1ns/1ps
`default_nettype none

module l2_tlb_write_port #(
   parameter int n_ports = 4
)
(
   input  wire logic                                s_axi_aclk,
   input  wire logic                                s_axi_aresetn,
   input  wire rab_cfg_pkg::cfg_write_t             wr,
   output rab_cfg_pkg::tlb_write_t [n_ports-1:0]    tlb_wr
);

   // **************************************************
   // one window per port, above the config region
   // **************************************************

   for (genvar j = 0; j < n_ports; j++)
   begin : g_port
      localparam logic [rab_cfg_pkg::data_width-1:0] win_base =
         (j + 1) * rab_cfg_pkg::region_size;
      localparam logic [rab_cfg_pkg::data_width-1:0] win_end =
         (j + 2) * rab_cfg_pkg::region_size;

      rab_cfg_pkg::tlb_write_t               port_q;
      logic [rab_cfg_pkg::data_width-1:0]    offset;
      logic                                  hit;

      assign offset = wr.addr - win_base;
      assign hit    = wr.valid && (wr.addr >= win_base) && (wr.addr < win_end);

      always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
      begin
         if (!s_axi_aresetn)
            port_q <= '0;
         else
         begin
            port_q.wren <= hit;   // one cycle per accepted write
            if (hit)
            begin
               port_q.addr <= {2'b00, offset[rab_cfg_pkg::data_width-1:2]};
               for (int b = 0; b < rab_cfg_pkg::strb_width; b++)
               begin
                  if (wr.strb[b])
                     port_q.data[b*8 +: 8] <= wr.data[b*8 +: 8];
               end
            end
         end
      end

      assign tlb_wr[j] = port_q;
   end

endmodule

`default_nettype wire

//--- design/rab_cfg_top.sv
`timescale 1ns/1ps
`default_nettype none

module rab_cfg_top #(
   parameter int n_ports     = 4,
   parameter int reg_entries = 196
)
(
   input  wire logic                                              s_axi_aclk,
   input  wire logic                                              s_axi_aresetn,
   input  wire logic [rab_cfg_pkg::data_width-1:0]                s_axi_awaddr,
   input  wire logic                                              s_axi_awvalid,
   output logic                                                   s_axi_awready,
   input  wire logic [rab_cfg_pkg::data_width-1:0]                s_axi_wdata,
   input  wire logic [rab_cfg_pkg::strb_width-1:0]                s_axi_wstrb,
   input  wire logic                                              s_axi_wvalid,
   output logic                                                   s_axi_wready,
   output rab_cfg_pkg::axi_resp_t                                 s_axi_bresp,
   output logic                                                   s_axi_bvalid,
   input  wire logic                                              s_axi_bready,
   input  wire logic [rab_cfg_pkg::data_width-1:0]                s_axi_araddr,
   input  wire logic                                              s_axi_arvalid,
   output logic                                                   s_axi_arready,
   output logic [rab_cfg_pkg::data_width-1:0]                     s_axi_rdata,
   output rab_cfg_pkg::axi_resp_t                                 s_axi_rresp,
   output logic                                                   s_axi_rvalid,
   input  wire logic                                              s_axi_rready,
   output logic [reg_entries-1:0][rab_cfg_pkg::data_width-1:0]    cfg_regs,
   output rab_cfg_pkg::tlb_write_t [n_ports-1:0]                  tlb_wr
);

   rab_cfg_pkg::cfg_write_t              wr;   // broadcast write pulse
   rab_cfg_pkg::cfg_read_t               rd;
   logic [rab_cfg_pkg::data_width-1:0]   rdata;

   axi_lite_slave u_axi_lite_slave (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .s_axi_awaddr  (s_axi_awaddr),
      .s_axi_awvalid (s_axi_awvalid),
      .s_axi_awready (s_axi_awready),
      .s_axi_wdata   (s_axi_wdata),
      .s_axi_wstrb   (s_axi_wstrb),
      .s_axi_wvalid  (s_axi_wvalid),
      .s_axi_wready  (s_axi_wready),
      .s_axi_bresp   (s_axi_bresp),
      .s_axi_bvalid  (s_axi_bvalid),
      .s_axi_bready  (s_axi_bready),
      .s_axi_araddr  (s_axi_araddr),
      .s_axi_arvalid (s_axi_arvalid),
      .s_axi_arready (s_axi_arready),
      .s_axi_rdata   (s_axi_rdata),
      .s_axi_rresp   (s_axi_rresp),
      .s_axi_rvalid  (s_axi_rvalid),
      .s_axi_rready  (s_axi_rready),
      .rdata         (rdata),
      .wr            (wr),
      .rd            (rd)
   );

   // config region, offset 0
   cfg_reg_bank #(.reg_entries(reg_entries)) u_cfg_reg_bank (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .wr            (wr),
      .rd            (rd),
      .rdata         (rdata),
      .cfg_regs      (cfg_regs)
   );

   l2_tlb_write_port #(.n_ports(n_ports)) u_l2_tlb_write_port (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .wr            (wr),
      .tlb_wr        (tlb_wr)
   );

endmodule

`default_nettype wire

//--- verif/rab_cfg_golden.txt
# op addr data strb expected, all hex; a C line gives the cfg_regs index in the addr column
# W write, R read and compare, C check cfg_regs, T write a TLB window and compare its pulse
R 00000000 00000000 0 00000000
R 0000030C 00000000 0 00000000
C 000000C3 00000000 0 00000000
W 00000000 DEADBEEF F 00000000
R 00000000 00000000 0 DEADBEEF
C 00000000 00000000 0 DEADBEEF
W 00000004 12345678 F 00000000
W 0000030C CAFEF00D F 00000000
R 0000030C 00000000 0 CAFEF00D
C 000000C3 00000000 0 CAFEF00D
W 00000000 11223344 1 00000000
R 00000000 00000000 0 DEADBE44
W 00000000 55667788 6 00000000
R 00000000 00000000 0 DE667744
W 00000004 AABBCCDD 8 00000000
R 00000004 00000000 0 AA345678
W 00000004 00000000 0 00000000
C 00000001 00000000 0 AA345678
T 00008000 01020304 F 01020304
T 00008010 AABBCCDD 3 0102CCDD
T 00010008 11111111 F 11111111
T 00018FFC 89ABCDEF C 89AB0000
T 00027FFC FFFFFFFF 1 000000FF
T 00008020 55667788 4 0166CCDD
R 00008000 00000000 0 00000000
R 00000310 00000000 0 00000000
R 00000400 00000000 0 00000000
R 00007FFC 00000000 0 00000000
W 00000310 FFFFFFFF F 00000000
W 00000400 FFFFFFFF F 00000000
W 00007000 FFFFFFFF F 00000000
C 00000000 00000000 0 DE667744
R 00000004 00000000 0 AA345678

//--- verif/tb_rab_cfg_checks.svh
`ifndef TB_RAB_CFG_CHECKS_SVH
`define TB_RAB_CFG_CHECKS_SVH

// **************************************************
// typed compares against golden values
// **************************************************

task automatic report_failure(input string why);
   $display("%s", why);
   $display("Finished with errors");
   $fatal(1, "run stopped");
endtask

task automatic check_data(input string name,
                          input logic [rab_cfg_pkg::data_width-1:0] exp,
                          input logic [rab_cfg_pkg::data_width-1:0] act);
   if (act !== exp)
      report_failure($sformatf("** Error at %0t: %s expected 0x%08h, got 0x%08h",
                               $time, name, exp, act));
endtask

task automatic check_resp(input string name,
                          input rab_cfg_pkg::axi_resp_t exp,
                          input rab_cfg_pkg::axi_resp_t act);
   if (act !== exp)
      report_failure($sformatf("** Error at %0t: %s expected %b, got %b",
                               $time, name, exp, act));
endtask

task automatic check_tlb(input string name,
                         input rab_cfg_pkg::tlb_write_t exp,
                         input rab_cfg_pkg::tlb_write_t act);
   string exp_s;
   string act_s;
   exp_s = $sformatf("wren=%b addr=0x%08h data=0x%08h", exp.wren, exp.addr, exp.data);
   act_s = $sformatf("wren=%b addr=0x%08h data=0x%08h", act.wren, act.addr, act.data);
   if (act !== exp)
      report_failure($sformatf("** Error at %0t: %s expected %s, got %s",
                               $time, name, exp_s, act_s));
endtask

// handshake levels right after reset
task automatic check_flag(input string name, input logic exp, input logic act);
   if (act !== exp)
      report_failure($sformatf("** Error at %0t: %s expected %b, got %b",
                               $time, name, exp, act));
endtask

`endif

//--- verif/tb_rab_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rab_cfg;

   localparam int n_ports         = 4;
   localparam int reg_entries     = 196;
   localparam int reset_cycles    = 10;
   localparam int cycles_per_line = 40;
   localparam int resp_wait_limit = 20;   // cycles for one b or r response

   logic                                  s_axi_aclk;
   logic                                  s_axi_aresetn;
   logic [rab_cfg_pkg::data_width-1:0]    s_axi_awaddr;
   logic                                  s_axi_awvalid;
   logic                                  s_axi_awready;
   logic [rab_cfg_pkg::data_width-1:0]    s_axi_wdata;
   logic [rab_cfg_pkg::strb_width-1:0]    s_axi_wstrb;
   logic                                  s_axi_wvalid;
   logic                                  s_axi_wready;
   rab_cfg_pkg::axi_resp_t                s_axi_bresp;
   logic                                  s_axi_bvalid;
   logic                                  s_axi_bready;
   logic [rab_cfg_pkg::data_width-1:0]    s_axi_araddr;
   logic                                  s_axi_arvalid;
   logic                                  s_axi_arready;
   logic [rab_cfg_pkg::data_width-1:0]    s_axi_rdata;
   rab_cfg_pkg::axi_resp_t                s_axi_rresp;
   logic                                  s_axi_rvalid;
   logic                                  s_axi_rready;

   logic [reg_entries-1:0][rab_cfg_pkg::data_width-1:0]    cfg_regs;
   logic [reg_entries-1:0][rab_cfg_pkg::data_width-1:0]    regs_before;
   rab_cfg_pkg::tlb_write_t [n_ports-1:0]                  tlb_wr;
   rab_cfg_pkg::tlb_write_t [n_ports-1:0]                  tlb_before;

   // golden lines, one entry per operation
   logic [7:0]                            op_q[$];
   logic [rab_cfg_pkg::data_width-1:0]    addr_q[$];
   logic [rab_cfg_pkg::data_width-1:0]    data_q[$];
   logic [rab_cfg_pkg::strb_width-1:0]    strb_q[$];
   logic [rab_cfg_pkg::data_width-1:0]    exp_q[$];

   int unsigned cycle_count = 0;
   int unsigned cycle_limit = 0;   // zero until the golden file is loaded

   int                        pulse_count [n_ports];
   logic                      prev_wren [n_ports];
   rab_cfg_pkg::tlb_write_t   pulse_seen [n_ports];

   `include "tb_rab_cfg_checks.svh"

   rab_cfg_top #(.n_ports(n_ports), .reg_entries(reg_entries)) u_dut (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .s_axi_awaddr  (s_axi_awaddr),
      .s_axi_awvalid (s_axi_awvalid),
      .s_axi_awready (s_axi_awready),
      .s_axi_wdata   (s_axi_wdata),
      .s_axi_wstrb   (s_axi_wstrb),
      .s_axi_wvalid  (s_axi_wvalid),
      .s_axi_wready  (s_axi_wready),
      .s_axi_bresp   (s_axi_bresp),
      .s_axi_bvalid  (s_axi_bvalid),
      .s_axi_bready  (s_axi_bready),
      .s_axi_araddr  (s_axi_araddr),
      .s_axi_arvalid (s_axi_arvalid),
      .s_axi_arready (s_axi_arready),
      .s_axi_rdata   (s_axi_rdata),
      .s_axi_rresp   (s_axi_rresp),
      .s_axi_rvalid  (s_axi_rvalid),
      .s_axi_rready  (s_axi_rready),
      .cfg_regs      (cfg_regs),
      .tlb_wr        (tlb_wr)
   );

   initial
   begin
      s_axi_aclk = 1'b0;
      forever #10 s_axi_aclk = ~s_axi_aclk;
   end

   always @(posedge s_axi_aclk)
   begin
      cycle_count++;
      if (cycle_limit != 0 && cycle_count >= cycle_limit)
         report_failure($sformatf("timeout: golden replay not done after %0d cycles",
                                  cycle_count));
   end

   // **************************************************
   // bus tasks, all start and end on a falling edge
   // **************************************************

   task automatic watch_tlb();
      for (int k = 0; k < n_ports; k++)
      begin
         if (tlb_wr[k].wren)
         begin
            if (prev_wren[k])
               report_failure($sformatf("tlb_wr[%0d] strobe lasted more than one cycle", k));
            pulse_count[k]++;
            pulse_seen[k] = tlb_wr[k];
         end
         prev_wren[k] = tlb_wr[k].wren;
      end
   endtask

   task automatic step_cycle();
      @(negedge s_axi_aclk);
      watch_tlb();
   endtask

   task automatic axi_write(input logic [rab_cfg_pkg::data_width-1:0] addr,
                            input logic [rab_cfg_pkg::data_width-1:0] data,
                            input logic [rab_cfg_pkg::strb_width-1:0] strb);
      int unsigned order;
      int unsigned bdelay;
      int unsigned waited;
      int unsigned spins;
      logic aw_done;
      logic w_done;
      logic b_done;
      logic aw_fire;
      logic w_fire;
      logic b_fire;
      rab_cfg_pkg::axi_resp_t resp;
      order   = $urandom_range(2, 0);   // 0 aw first, 1 w first, 2 together
      bdelay  = $urandom_range(3, 0);
      waited  = 0;
      spins   = 0;
      aw_done = 1'b0;
      w_done  = 1'b0;
      b_done  = 1'b0;
      resp    = rab_cfg_pkg::resp_slverr;
      s_axi_awaddr = addr;
      s_axi_wdata  = data;
      s_axi_wstrb  = strb;
      s_axi_awvalid = (order != 1);
      s_axi_wvalid  = (order != 0);
      while (!b_done)
      begin
         aw_fire = s_axi_awvalid && s_axi_awready;
         w_fire  = s_axi_wvalid && s_axi_wready;
         b_fire  = s_axi_bvalid && s_axi_bready;
         if (b_fire)
            resp = s_axi_bresp;
         step_cycle();
         if (aw_fire)
         begin
            s_axi_awvalid = 1'b0;
            aw_done       = 1'b1;
         end
         if (w_fire)
         begin
            s_axi_wvalid = 1'b0;
            w_done       = 1'b1;
         end
         if (b_fire)
         begin
            s_axi_bready = 1'b0;
            b_done       = 1'b1;
         end
         if (aw_done && !w_done && !s_axi_wvalid)
            s_axi_wvalid = 1'b1;   // second half of a split write
         if (w_done && !aw_done && !s_axi_awvalid)
            s_axi_awvalid = 1'b1;
         if (aw_done && w_done && !b_done && !s_axi_bready)
         begin
            if (waited >= bdelay)
               s_axi_bready = 1'b1;
            else
               waited++;
         end
         spins++;
         if (spins > resp_wait_limit)
            report_failure($sformatf("write to 0x%08h got no B response", addr));
      end
      check_resp("s_axi_bresp", rab_cfg_pkg::resp_okay, resp);
   endtask

   task automatic axi_read(input logic [rab_cfg_pkg::data_width-1:0] addr,
                           output logic [rab_cfg_pkg::data_width-1:0] data);
      int unsigned rdelay;
      int unsigned waited;
      int unsigned spins;
      logic ar_fire;
      logic r_fire;
      logic r_done;
      rab_cfg_pkg::axi_resp_t resp;
      rdelay = $urandom_range(3, 0);
      waited = 0;
      spins  = 0;
      r_done = 1'b0;
      resp   = rab_cfg_pkg::resp_slverr;
      data   = '0;
      s_axi_araddr  = addr;
      s_axi_arvalid = 1'b1;
      while (!r_done)
      begin
         ar_fire = s_axi_arvalid && s_axi_arready;
         r_fire  = s_axi_rvalid && s_axi_rready;
         if (r_fire)
         begin
            data = s_axi_rdata;
            resp = s_axi_rresp;
         end
         step_cycle();
         if (ar_fire)
            s_axi_arvalid = 1'b0;
         if (r_fire)
         begin
            s_axi_rready = 1'b0;
            r_done       = 1'b1;
         end
         else if (!s_axi_arvalid && !s_axi_rready)
         begin
            if (waited >= rdelay)
               s_axi_rready = 1'b1;   // rdata must hold through the delay
            else
               waited++;
         end
         spins++;
         if (spins > resp_wait_limit)
            report_failure($sformatf("read of 0x%08h got no R response", addr));
      end
      check_resp("s_axi_rresp", rab_cfg_pkg::resp_okay, resp);
   endtask

   // window write, one pulse on the owning port only
   task automatic tlb_write_check(input logic [rab_cfg_pkg::data_width-1:0] addr,
                                  input logic [rab_cfg_pkg::data_width-1:0] data,
                                  input logic [rab_cfg_pkg::strb_width-1:0] strb,
                                  input logic [rab_cfg_pkg::data_width-1:0] exp_data);
      int unsigned port;
      logic [rab_cfg_pkg::data_width-1:0] base;
      rab_cfg_pkg::tlb_write_t exp;
      port = addr / rab_cfg_pkg::region_size - 1;
      if (port >= n_ports)
         report_failure($sformatf("T line address 0x%08h is in no TLB window", addr));
      base        = (port + 1) * rab_cfg_pkg::region_size;
      exp.wren    = 1'b1;
      exp.addr    = (addr - base) >> 2;   // word offset in window
      exp.data    = exp_data;
      regs_before = cfg_regs;
      tlb_before  = tlb_wr;
      for (int k = 0; k < n_ports; k++)
         pulse_count[k] = 0;
      axi_write(addr, data, strb);
      repeat (3) step_cycle();
      if (pulse_count[port] == 0)
         report_failure($sformatf("no write strobe on tlb_wr[%0d]", port));
      if (pulse_count[port] > 1)
         report_failure($sformatf("more than one write strobe on tlb_wr[%0d]", port));
      check_tlb($sformatf("tlb_wr[%0d]", port), exp, pulse_seen[port]);
      for (int k = 0; k < n_ports; k++)
      begin
         if (k != port && pulse_count[k] != 0)
            report_failure($sformatf("unexpected write strobe on tlb_wr[%0d]", k));
         if (k != port)
            check_tlb($sformatf("tlb_wr[%0d]", k), tlb_before[k], tlb_wr[k]);
      end
      for (int i = 0; i < reg_entries; i++)
         check_data($sformatf("cfg_regs[%0d]", i), regs_before[i], cfg_regs[i]);
   endtask

   // **************************************************
   // golden file
   // **************************************************

   task automatic load_golden();
      int fd;
      int got;
      int ch;
      logic [7:0] op;
      logic [rab_cfg_pkg::data_width-1:0] addr;
      logic [rab_cfg_pkg::data_width-1:0] data;
      logic [rab_cfg_pkg::strb_width-1:0] strb;
      logic [rab_cfg_pkg::data_width-1:0] exp;
      fd = $fopen("verif/rab_cfg_golden.txt", "r");
      if (fd == 0)
         report_failure("cannot open verif/rab_cfg_golden.txt");
      got = $fscanf(fd, " %c", op);
      while (got == 1)
      begin
         if (op == "#")
         begin
            ch = $fgetc(fd);
            while (ch != "\n" && ch != -1)
               ch = $fgetc(fd);
         end
         else
         begin
            got = $fscanf(fd, "%h %h %h %h", addr, data, strb, exp);
            if (got != 4)
               report_failure($sformatf("malformed golden line after op %c", op));
            op_q.push_back(op);
            addr_q.push_back(addr);
            data_q.push_back(data);
            strb_q.push_back(strb);
            exp_q.push_back(exp);
         end
         got = $fscanf(fd, " %c", op);
      end
      $fclose(fd);
      if (op_q.size() == 0)
         report_failure("golden file holds no operations");
   endtask

   task automatic run_golden();
      logic [rab_cfg_pkg::data_width-1:0] rdata;
      for (int i = 0; i < op_q.size(); i++)
      begin
         case (op_q[i])
            "W": axi_write(addr_q[i], data_q[i], strb_q[i]);
            "R":
            begin
               axi_read(addr_q[i], rdata);
               check_data($sformatf("s_axi_rdata at 0x%08h", addr_q[i]), exp_q[i], rdata);
            end
            "C":
            begin
               if (addr_q[i] >= reg_entries)
                  report_failure($sformatf("C line index %0d is past cfg_regs", addr_q[i]));
               check_data($sformatf("cfg_regs[%0d]", addr_q[i]), exp_q[i],
                          cfg_regs[addr_q[i]]);
            end
            "T": tlb_write_check(addr_q[i], data_q[i], strb_q[i], exp_q[i]);
            default: report_failure($sformatf("unknown golden op %c", op_q[i]));
         endcase
         step_cycle();
      end
   endtask

   initial
   begin
      s_axi_aresetn = 1'b0;
      s_axi_awaddr  = '0;
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = '0;
      s_axi_wstrb   = '0;
      s_axi_wvalid  = 1'b0;
      s_axi_bready  = 1'b0;
      s_axi_araddr  = '0;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b0;
      for (int k = 0; k < n_ports; k++)
      begin
         pulse_count[k] = 0;
         prev_wren[k]   = 1'b0;
         pulse_seen[k]  = '0;
      end
      void'($urandom(63893));
      load_golden();
      cycle_limit = cycles_per_line * op_q.size() + reset_cycles;
      repeat (reset_cycles) @(negedge s_axi_aclk);
      s_axi_aresetn = 1'b1;
      step_cycle();
      check_flag("s_axi_awready", 1'b1, s_axi_awready);
      check_flag("s_axi_wready", 1'b1, s_axi_wready);
      check_flag("s_axi_arready", 1'b1, s_axi_arready);
      check_flag("s_axi_bvalid", 1'b0, s_axi_bvalid);
      check_flag("s_axi_rvalid", 1'b0, s_axi_rvalid);
      run_golden();
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire
